/* build.f */
+incdir+verification
rtl/id_pkg.sv
rtl/id_decode.sv
rtl/id_bypass.sv
rtl/id_branch.sv
rtl/id_control.sv
rtl/id_stage.sv
verification/tb_id_stage.sv

/* run_sim.sh */
#!/bin/bash
# compile with Verilator and run; passes only if the testbench reports success
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
        --top-module tb_id_stage -o sim_tb \
        && ./obj_dir/sim_tb | tee /dev/stderr | grep -qx "TB PASSED" \
        && echo "simulation passed" \
        || { echo "simulation failed"; exit 1; }

/* verification/id_ref.svh */
`ifndef ID_REF_SVH
`define ID_REF_SVH

typedef struct packed {
        id_pkg::alu_op_t   alu_op;
        id_pkg::word_t     src1;
        id_pkg::word_t     src2;
        id_pkg::word_t     store_data;
        id_pkg::word_t     target;
        id_pkg::reg_addr_t dest;
        id_pkg::reg_addr_t raddr2;
        logic              mem_we;
        logic              res_from_mem;
        logic              gr_we;
        logic              redirect;
} id_exp_t;

// stores and conditional branches read rd on port 2
function automatic id_pkg::reg_addr_t ref_src2_addr(input id_pkg::inst_t inst);
        if ((inst[31:26] >= 6'h16 && inst[31:26] <= 6'h1b) || inst[31:22] == 10'h0a6) begin
                return inst[4:0];
        end
        return inst[14:10];
endfunction

function automatic id_exp_t id_ref(input id_pkg::word_t pc, input id_pkg::inst_t inst,
                                   input logic predict, input id_pkg::word_t rj_v,
                                   input id_pkg::word_t rk_v);
        id_exp_t       e;
        id_pkg::word_t si12;
        id_pkg::word_t off16;
        id_pkg::word_t off26;
        logic          taken;
        e = '0;
        taken = 1'b0;
        si12 = {{20{inst[21]}}, inst[21:10]};
        off16 = {{14{inst[25]}}, inst[25:10], 2'b00};
        off26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
        e.src1 = rj_v;
        e.src2 = rk_v;
        e.store_data = rk_v;
        e.dest = inst[4:0];
        e.raddr2 = ref_src2_addr(inst);
        e.target = pc + off16;
        if (inst[31:20] == 12'h001) begin
                case (inst[19:15])
                        5'h00: e.alu_op[id_pkg::ALU_ADD] = 1'b1;
                        5'h02: e.alu_op[id_pkg::ALU_SUB] = 1'b1;
                        5'h04: e.alu_op[id_pkg::ALU_SLT] = 1'b1;
                        5'h05: e.alu_op[id_pkg::ALU_SLTU] = 1'b1;
                        5'h08: e.alu_op[id_pkg::ALU_NOR] = 1'b1;
                        5'h09: e.alu_op[id_pkg::ALU_AND] = 1'b1;
                        5'h0a: e.alu_op[id_pkg::ALU_OR] = 1'b1;
                        5'h0b: e.alu_op[id_pkg::ALU_XOR] = 1'b1;
                        5'h0e: e.alu_op[id_pkg::ALU_SLL] = 1'b1;
                        5'h0f: e.alu_op[id_pkg::ALU_SRL] = 1'b1;
                        5'h10: e.alu_op[id_pkg::ALU_SRA] = 1'b1;
                        default: ;
                endcase
        end
        else if (inst[31:20] == 12'h004) begin
                case (inst[19:15])      // ALU shifts by the low five bits only
                        5'h01: e.alu_op[id_pkg::ALU_SLL] = 1'b1;
                        5'h09: e.alu_op[id_pkg::ALU_SRL] = 1'b1;
                        5'h11: e.alu_op[id_pkg::ALU_SRA] = 1'b1;
                        default: ;
                endcase
                if (e.alu_op != '0) e.src2 = si12;
        end
        else if (inst[31:25] == 7'b0001010 || inst[31:25] == 7'b0001110) begin
                e.src2 = {inst[24:5], 12'b0};
                if (inst[27]) begin
                        e.alu_op[id_pkg::ALU_ADD] = 1'b1;   // pcaddu12i
                        e.src1 = pc;
                end
                else begin
                        e.alu_op[id_pkg::ALU_LUI] = 1'b1;
                end
        end
        else begin
                case (inst[31:26])
                        6'h13: begin
                                e.alu_op[id_pkg::ALU_ADD] = 1'b1;
                                e.src1 = pc;
                                e.src2 = 32'd4;
                                e.target = rj_v + off16;
                                taken = 1'b1;
                        end
                        6'h14: begin
                                e.target = pc + off26;
                                taken = 1'b1;
                        end
                        6'h15: begin
                                e.alu_op[id_pkg::ALU_ADD] = 1'b1;
                                e.src1 = pc;
                                e.src2 = 32'd4;
                                e.dest = 5'd1;
                                e.target = pc + off26;
                                taken = 1'b1;
                        end
                        6'h16: taken = rj_v == rk_v;
                        6'h17: taken = rj_v != rk_v;
                        6'h18: taken = $signed(rj_v) < $signed(rk_v);
                        6'h19: taken = $signed(rj_v) >= $signed(rk_v);
                        6'h1a: taken = rj_v < rk_v;
                        6'h1b: taken = rj_v >= rk_v;
                        default: begin
                                case (inst[31:22])
                                        10'h008: e.alu_op[id_pkg::ALU_SLT] = 1'b1;
                                        10'h009: e.alu_op[id_pkg::ALU_SLTU] = 1'b1;
                                        10'h00a: e.alu_op[id_pkg::ALU_ADD] = 1'b1;
                                        10'h00d: e.alu_op[id_pkg::ALU_AND] = 1'b1;
                                        10'h00e: e.alu_op[id_pkg::ALU_OR] = 1'b1;
                                        10'h00f: e.alu_op[id_pkg::ALU_XOR] = 1'b1;
                                        10'h0a2: e.res_from_mem = 1'b1;
                                        10'h0a6: e.mem_we = 1'b1;
                                        default: ;
                                endcase
                                if (e.mem_we || e.res_from_mem) begin
                                        e.alu_op[id_pkg::ALU_ADD] = 1'b1;
                                end
                                if (e.alu_op != '0) begin
                                        e.src2 = inst[31:22] >= 10'h00d && inst[31:22] <= 10'h00f
                                                 ? {20'b0, inst[21:10]} : si12;
                                end
                        end
                endcase
        end
        e.gr_we = (e.alu_op != '0) && !e.mem_we;
        e.redirect = (taken != predict) || inst[31:26] == 6'h13;
        return e;
endfunction

`endif

/* verification/tb_id_stage.sv */
`timescale 1ns/10ps

module tb_id_stage;

        localparam int RESET_CYC = 5;
        localparam int N_INSTS   = 82;

        logic              clk, rst, if_to_id, if_predict, flush, ex_allowin;
        id_pkg::word_t     if_pc, rf_rdata1, rf_rdata2, ex_fwd_data, mem_fwd_data;
        id_pkg::inst_t     if_inst;
        logic              ex_fwd_valid, ex_is_load, mem_fwd_valid, mem_is_load, mem_done;
        id_pkg::reg_addr_t ex_fwd_addr, mem_fwd_addr, rf_raddr1, rf_raddr2, ex_dest;
        logic              allowin, id_to_ex, ex_mem_we, ex_res_from_mem, ex_gr_we, redirect;
        id_pkg::word_t     ex_pc, ex_src1, ex_src2, ex_store_data, redirect_target;
        id_pkg::alu_op_t   ex_alu_op;

        `include "id_ref.svh"

        integer            seed;
        int                errors, checks;
        logic              pending, stall_exp, hold_exp;
        id_pkg::word_t     cur_pc;
        id_pkg::inst_t     cur_inst;
        logic              cur_pred;

        id_stage dut (.*);

        always #10 clk = ~clk;

        task automatic check_word(input id_pkg::word_t got, input id_pkg::word_t exp,
                                  input string msg);
                checks++;
                if (got !== exp) begin
                        errors++;
                        $display("CHECK FAILED at %0t: %s got %h expected %h",
                                 $time, msg, got, exp);
                end
        endtask

        task automatic check_op(input id_pkg::alu_op_t got, input id_pkg::alu_op_t exp,
                                input string msg);
                checks++;
                if (got !== exp) begin
                        errors++;
                        $display("CHECK FAILED at %0t: %s got %h expected %h",
                                 $time, msg, got, exp);
                end
        endtask

        task automatic check_reg(input id_pkg::reg_addr_t got, input id_pkg::reg_addr_t exp,
                                 input string msg);
                checks++;
                if (got !== exp) begin
                        errors++;
                        $display("CHECK FAILED at %0t: %s got %0d expected %0d",
                                 $time, msg, got, exp);
                end
        endtask

        task automatic check_bit(input logic got, input logic exp, input string msg);
                checks++;
                if (got !== exp) begin
                        errors++;
                        $display("CHECK FAILED at %0t: %s got %b expected %b",
                                 $time, msg, got, exp);
                end
        endtask

        function automatic id_pkg::word_t fwd_pick(input id_pkg::reg_addr_t a,
                                                   input id_pkg::word_t rf);
                if (ex_fwd_valid && ex_fwd_addr == a) return ex_fwd_data;
                if (mem_fwd_valid && mem_fwd_addr == a) return mem_fwd_data;
                return rf;
        endfunction

        task automatic check_bundle(input id_exp_t e);
                check_reg(rf_raddr1, cur_inst[9:5], "rf_raddr1");
                check_reg(rf_raddr2, e.raddr2, "rf_raddr2");
                check_word(ex_pc, cur_pc, "ex_pc");
                check_word(ex_src1, e.src1, "ex_src1");
                check_word(ex_src2, e.src2, "ex_src2");
                check_op(ex_alu_op, e.alu_op, "ex_alu_op");
                check_bit(ex_mem_we, e.mem_we, "ex_mem_we");
                check_bit(ex_res_from_mem, e.res_from_mem, "ex_res_from_mem");
                check_bit(ex_gr_we, e.gr_we, "ex_gr_we");
                check_word(ex_store_data, e.store_data, "ex_store_data");
                check_reg(ex_dest, e.dest, "ex_dest");
                check_bit(redirect, e.redirect, "redirect");
                if (e.redirect) check_word(redirect_target, e.target, "redirect_target");
        endtask

        always @(posedge clk) begin : compare
                id_exp_t e;
                e = id_ref(cur_pc, cur_inst, cur_pred, fwd_pick(cur_inst[9:5], rf_rdata1),
                           fwd_pick(ref_src2_addr(cur_inst), rf_rdata2));
                if (!rst) begin
                        if (!pending) begin
                                if (id_to_ex) begin
                                        errors++;
                                        $display("an instruction issued while none was expected at %0t",
                                                 $time);
                                end
                        end
                        else if (stall_exp) begin
                                check_bit(id_to_ex, 1'b0, "id_to_ex under load hazard");
                                check_bit(allowin, 1'b0, "allowin under load hazard");
                                check_bit(redirect, 1'b0, "redirect under load hazard");
                        end
                        else if (id_to_ex || hold_exp) begin
                                check_bundle(e);
                                if (hold_exp) begin
                                        check_bit(allowin, 1'b0,
                                                  "allowin under back-pressure");
                                end
                                if (id_to_ex) begin
                                        pending <= 1'b0;
                                end
                        end
                end
        end

        task automatic send(input id_pkg::inst_t inst, input logic pred);
                id_pkg::word_t pc;
                while (pending) @(posedge clk);
                pc = {$random(seed)} & 32'hffff_fffc;
                if_to_id   <= 1'b1;
                if_pc      <= pc;
                if_inst    <= inst;
                if_predict <= pred;
                rf_rdata1  <= $random(seed);
                rf_rdata2  <= $random(seed);
                cur_pc     <= pc;
                cur_inst   <= inst;
                cur_pred   <= pred;
                @(posedge clk);
                if_to_id   <= 1'b0;
                pending    <= 1'b1;     // the stage holds it from this edge on
        endtask

        task automatic wait_issue();
                @(posedge clk);
                while (pending) @(posedge clk);
        endtask

        function automatic id_pkg::inst_t alu_inst();
                logic [4:0]  fn3 [11] = '{5'h00, 5'h02, 5'h04, 5'h05, 5'h08, 5'h09,
                                          5'h0a, 5'h0b, 5'h0e, 5'h0f, 5'h10};
                logic [9:0]  op_i [6] = '{10'h008, 10'h009, 10'h00a,
                                          10'h00d, 10'h00e, 10'h00f};
                logic [4:0]  fn_s [3] = '{5'h01, 5'h09, 5'h11};
                logic [31:0] r;
                r = $random(seed);
                case ({$random(seed)} % 9)
                        0: return {12'h001, fn3[{$random(seed)} % 11], r[14:0]};
                        1: return {12'h004, fn_s[{$random(seed)} % 3], r[14:0]};
                        2: return {op_i[{$random(seed)} % 6], r[21:0]};
                        3: return {7'b0001010, r[24:0]};
                        4: return {7'b0001110, r[24:0]};
                        5: return {10'h0a2, r[21:0]};
                        6: return {10'h0a6, r[21:0]};
                        7: return {6'h15, r[25:0]};
                        default: return r;     // mostly unknown words
                endcase
        endfunction

        initial begin
                id_pkg::inst_t inst;
                seed = 3;
                clk = 0;
                rst = 1;
                if_to_id = 0;
                if_pc = '0;
                if_inst = '0;
                if_predict = 0;
                flush = 0;
                ex_allowin = 1;
                rf_rdata1 = '0;
                rf_rdata2 = '0;
                ex_fwd_valid = 0;
                ex_fwd_addr = '0;
                ex_fwd_data = '0;
                ex_is_load = 0;
                mem_fwd_valid = 0;
                mem_fwd_addr = '0;
                mem_fwd_data = '0;
                mem_is_load = 0;
                mem_done = 1;
                errors = 0;
                checks = 0;
                pending = 0;
                stall_exp = 0;
                hold_exp = 0;
                cur_pc = '0;
                cur_inst = '0;
                cur_pred = 0;
                repeat (RESET_CYC) @(posedge clk);
                rst <= 1'b0;

                repeat (30) begin
                        send(alu_inst(), 1'b0);
                        wait_issue();
                end

                for (int c = 0; c < 3; c++) begin
                        ex_fwd_valid  <= c == 0;
                        mem_fwd_valid <= c < 2;
                        ex_fwd_addr   <= 5'd5;
                        mem_fwd_addr  <= 5'd5;
                        ex_fwd_data   <= $random(seed);
                        mem_fwd_data  <= $random(seed);
                        send({12'h001, 5'h00, 5'd6, 5'd5, 5'd3}, 1'b0);
                        wait_issue();
                        send({10'h0a6, 12'h010, 5'd9, 5'd5}, 1'b0);
                        wait_issue();
                end
                repeat (12) begin      // random producers over a few registers
                        ex_fwd_valid  <= $random(seed);
                        mem_fwd_valid <= $random(seed);
                        ex_fwd_addr   <= {$random(seed)} % 4;
                        mem_fwd_addr  <= {$random(seed)} % 4;
                        inst = alu_inst();
                        send({inst[31:15], 3'b000, inst[11:10], 3'b000, inst[6:5], inst[4:0]},
                             1'b0);
                        wait_issue();
                end

                ex_fwd_valid <= 1'b1;
                ex_fwd_addr <= 5'd7;
                ex_is_load <= 1'b1;
                mem_fwd_valid <= 1'b0;
                stall_exp <= 1'b1;
                send({6'h16, 16'h0040, 5'd7, 5'd8}, 1'b0);
                repeat (4) @(posedge clk);
                ex_is_load <= 1'b0;
                stall_exp <= 1'b0;
                wait_issue();
                ex_fwd_valid <= 1'b0;
                mem_fwd_valid <= 1'b1;
                mem_fwd_addr <= 5'd8;
                mem_is_load <= 1'b1;
                mem_done <= 1'b0;
                stall_exp <= 1'b1;
                send({6'h17, 16'hff00, 5'd7, 5'd8}, 1'b1);
                repeat (4) @(posedge clk);
                mem_done <= 1'b1;
                stall_exp <= 1'b0;
                wait_issue();
                mem_is_load <= 1'b0;
                mem_fwd_valid <= 1'b0;

                repeat (30) begin
                        inst = $random(seed);
                        inst[31:26] = 6'h13 + {$random(seed)} % 9;
                        send(inst, $random(seed));
                        if ($random(seed) & 1) rf_rdata2 <= rf_rdata1;   // force equal operands
                        wait_issue();
                end

                ex_allowin <= 1'b0;
                hold_exp <= 1'b1;
                send(alu_inst(), 1'b0);
                repeat (3) @(posedge clk);
                ex_allowin <= 1'b1;
                hold_exp <= 1'b0;
                wait_issue();

                ex_allowin <= 1'b0;
                send({12'h001, 5'h00, 5'd2, 5'd1, 5'd4}, 1'b0);
                flush <= 1'b1;
                pending <= 1'b0;
                @(posedge clk);
                flush <= 1'b0;
                @(posedge clk);
                check_bit(allowin, 1'b1, "allowin after flush");
                ex_allowin <= 1'b1;
                repeat (3) @(posedge clk);

                $display("errors: %0d in %0d checks", errors, checks);
                if (errors == 0) begin
                        $display("TB PASSED");
                end
                else begin
                        $display("TB FAILED");
                end
                $finish;
        end

        initial begin : watchdog
                #(20 * (RESET_CYC + 200 * N_INSTS));
                $display("simulation timed out waiting for an instruction to issue");
                $display("TB FAILED");
                $finish;
        end

endmodule

/* rtl/id_stage.sv */
`timescale 1ns/10ps

module id_stage (
        input  logic              clk,
        input  logic              rst,
        input  logic              if_to_id,
        input  id_pkg::word_t     if_pc,
        input  id_pkg::inst_t     if_inst,
        input  logic              if_predict,
        output logic              allowin,
        input  logic              flush,
        output id_pkg::reg_addr_t rf_raddr1,
        output id_pkg::reg_addr_t rf_raddr2,
        input  id_pkg::word_t     rf_rdata1,
        input  id_pkg::word_t     rf_rdata2,
        input  logic              ex_fwd_valid,
        input  id_pkg::reg_addr_t ex_fwd_addr,
        input  id_pkg::word_t     ex_fwd_data,
        input  logic              ex_is_load,
        input  logic              mem_fwd_valid,
        input  id_pkg::reg_addr_t mem_fwd_addr,
        input  id_pkg::word_t     mem_fwd_data,
        input  logic              mem_is_load,
        input  logic              mem_done,
        input  logic              ex_allowin,
        output logic              id_to_ex,
        output id_pkg::word_t     ex_pc,
        output id_pkg::word_t     ex_src1,
        output id_pkg::word_t     ex_src2,
        output id_pkg::alu_op_t   ex_alu_op,
        output logic              ex_mem_we,
        output logic              ex_res_from_mem,
        output logic              ex_gr_we,
        output id_pkg::word_t     ex_store_data,
        output id_pkg::reg_addr_t ex_dest,
        output logic              redirect,
        output id_pkg::word_t     redirect_target
);

        id_pkg::word_t pc, imm, br_offs, rj_value, rkd_value;
        logic          issue, load_hazard, predict, src1_is_pc, src2_is_imm, link;
        logic          is_beq, is_bne, is_blt, is_bge, is_bltu, is_bgeu, is_jirl, is_uncond;

        id_control u_control (
                .clk, .rst, .if_to_id, .flush, .load_hazard, .ex_allowin,
                .valid(), .issue, .id_to_ex, .allowin
        );

        id_decode u_decode (
                .clk, .rst, .if_to_id, .if_pc, .if_inst, .if_predict,
                .pc, .predict, .rj(rf_raddr1), .raddr2(rf_raddr2), .alu_op(ex_alu_op),
                .imm, .br_offs, .src1_is_pc, .src2_is_imm, .mem_we(ex_mem_we),
                .res_from_mem(ex_res_from_mem), .gr_we(ex_gr_we), .dest(ex_dest),
                .is_beq, .is_bne, .is_blt, .is_bge, .is_bltu, .is_bgeu, .is_jirl, .is_uncond
        );

        id_bypass u_bypass (
                .raddr1(rf_raddr1), .raddr2(rf_raddr2), .rf_rdata1, .rf_rdata2,
                .ex_fwd_valid, .ex_fwd_addr, .ex_fwd_data, .ex_is_load,
                .mem_fwd_valid, .mem_fwd_addr, .mem_fwd_data, .mem_is_load, .mem_done,
                .rj_value, .rkd_value, .load_hazard
        );

        id_branch u_branch (
                .issue, .predict, .is_beq, .is_bne, .is_blt, .is_bge, .is_bltu, .is_bgeu,
                .is_jirl, .is_uncond, .pc, .rj_value, .rkd_value, .br_offs, .imm,
                .redirect, .redirect_target
        );

        assign link = is_jirl | is_uncond & ex_gr_we;  // jirl and bl write pc + 4

        assign ex_pc         = pc;
        assign ex_src1       = src1_is_pc ? pc : rj_value;
        assign ex_src2       = link ? 32'd4 : src2_is_imm ? imm : rkd_value;
        assign ex_store_data = rkd_value;

endmodule

/* rtl/id_control.sv */
`timescale 1ns/10ps

module id_control (
        input  logic clk,
        input  logic rst,
        input  logic if_to_id,
        input  logic flush,
        input  logic load_hazard,
        input  logic ex_allowin,
        output logic valid,
        output logic issue,
        output logic id_to_ex,
        output logic allowin
);

        id_pkg::stage_state_t state;
        logic                 ready_go;

        always_ff @(posedge clk) begin
                if (rst || flush) begin
                        state <= id_pkg::ST_EMPTY;
                end
                else if (if_to_id) begin
                        state <= id_pkg::ST_HOLD;      // refill wins over leaving
                end
                else if (id_to_ex) begin
                        state <= id_pkg::ST_EMPTY;
                end
        end

        assign valid    = (state == id_pkg::ST_HOLD) & ~flush;
        assign ready_go = ~load_hazard;
        assign issue    = valid & ready_go;
        assign id_to_ex = issue & ex_allowin;
        assign allowin  = ~valid | id_to_ex;

        // fetch respects back-pressure
        assert property (@(posedge clk) disable iff (rst) if_to_id |-> allowin);

        assert property (@(posedge clk) disable iff (rst) id_to_ex |-> valid && !flush);

endmodule

/* rtl/id_branch.sv */
`timescale 1ns/10ps

module id_branch (
        input  logic          issue,
        input  logic          predict,
        input  logic          is_beq,
        input  logic          is_bne,
        input  logic          is_blt,
        input  logic          is_bge,
        input  logic          is_bltu,
        input  logic          is_bgeu,
        input  logic          is_jirl,
        input  logic          is_uncond,
        input  id_pkg::word_t pc,
        input  id_pkg::word_t rj_value,
        input  id_pkg::word_t rkd_value,
        input  id_pkg::word_t br_offs,
        input  id_pkg::word_t imm,
        output logic          redirect,
        output id_pkg::word_t redirect_target
);

        logic eq;
        logic lt;
        logic ltu;
        logic taken;

        assign eq  = rj_value == rkd_value;
        assign lt  = $signed(rj_value) < $signed(rkd_value);
        assign ltu = rj_value < rkd_value;

        assign taken = is_beq  &  eq
                     | is_bne  & ~eq
                     | is_blt  &  lt
                     | is_bge  & ~lt
                     | is_bltu &  ltu
                     | is_bgeu & ~ltu
                     | is_jirl
                     | is_uncond;

        // fetch never predicts jirl's register target, so it always redirects
        assign redirect = issue & ((taken ^ predict) | is_jirl);

        assign redirect_target = is_jirl ? rj_value + imm : pc + br_offs;

endmodule

/* rtl/id_bypass.sv */
`timescale 1ns/10ps

module id_bypass (
        input  id_pkg::reg_addr_t raddr1,
        input  id_pkg::reg_addr_t raddr2,
        input  id_pkg::word_t     rf_rdata1,
        input  id_pkg::word_t     rf_rdata2,
        input  logic              ex_fwd_valid,
        input  id_pkg::reg_addr_t ex_fwd_addr,
        input  id_pkg::word_t     ex_fwd_data,
        input  logic              ex_is_load,
        input  logic              mem_fwd_valid,
        input  id_pkg::reg_addr_t mem_fwd_addr,
        input  id_pkg::word_t     mem_fwd_data,
        input  logic              mem_is_load,
        input  logic              mem_done,
        output id_pkg::word_t     rj_value,
        output id_pkg::word_t     rkd_value,
        output logic              load_hazard
);

        logic ex_hit;
        logic mem_hit;

        // youngest producer wins
        function automatic id_pkg::word_t fwd_sel(
                input id_pkg::reg_addr_t addr,
                input id_pkg::word_t     rf_data
        );
                if (ex_fwd_valid && ex_fwd_addr == addr) begin
                        return ex_fwd_data;
                end
                if (mem_fwd_valid && mem_fwd_addr == addr) begin
                        return mem_fwd_data;
                end
                return rf_data;
        endfunction

        always_comb begin
                rj_value  = fwd_sel(raddr1, rf_rdata1);
                rkd_value = fwd_sel(raddr2, rf_rdata2);
        end

        assign ex_hit  = ex_fwd_addr != '0 && (ex_fwd_addr == raddr1 || ex_fwd_addr == raddr2);
        assign mem_hit = mem_fwd_addr != '0
                         && (mem_fwd_addr == raddr1 || mem_fwd_addr == raddr2);

        assign load_hazard = ex_is_load & ex_hit | mem_is_load & ~mem_done & mem_hit;

endmodule

/* rtl/id_decode.sv */
`timescale 1ns/10ps

module id_decode (
        input  logic              clk,
        input  logic              rst,
        input  logic              if_to_id,
        input  id_pkg::word_t     if_pc,
        input  id_pkg::inst_t     if_inst,
        input  logic              if_predict,
        output id_pkg::word_t     pc,
        output logic              predict,
        output id_pkg::reg_addr_t rj,
        output id_pkg::reg_addr_t raddr2,
        output id_pkg::alu_op_t   alu_op,
        output id_pkg::word_t     imm,
        output id_pkg::word_t     br_offs,
        output logic              src1_is_pc,
        output logic              src2_is_imm,
        output logic              mem_we,
        output logic              res_from_mem,
        output logic              gr_we,
        output id_pkg::reg_addr_t dest,
        output logic              is_beq,
        output logic              is_bne,
        output logic              is_blt,
        output logic              is_bge,
        output logic              is_bltu,
        output logic              is_bgeu,
        output logic              is_jirl,
        output logic              is_uncond
);

        id_pkg::inst_t     inst;
        id_pkg::reg_addr_t rd;
        logic [4:0]        fn;                  // minor opcode of 3R and shift forms
        logic [9:0]        op_hi;
        logic              is_3r, is_shi, sh_imm;
        logic              inst_addi, inst_slti, inst_sltui;
        logic              inst_andi, inst_ori, inst_xori;
        logic              inst_ld_w, inst_st_w, inst_lu12i, inst_pcadd;
        logic              inst_b, inst_bl, src_reg_is_rd;

        always_ff @(posedge clk) begin
                if (rst) begin
                        inst    <= '0;          // all-zero word decodes as nothing
                        predict <= 1'b0;
                end
                else if (if_to_id) begin
                        inst    <= if_inst;
                        predict <= if_predict;
                end
        end

        always_ff @(posedge clk) begin
                if (if_to_id) begin
                        pc <= if_pc;
                end
        end

        assign rd     = inst[4:0];
        assign rj     = inst[9:5];
        assign fn     = inst[19:15];
        assign op_hi  = inst[31:22];
        assign is_3r  = inst[31:20] == 12'h001;
        assign is_shi = inst[31:20] == 12'h004;
        assign sh_imm = is_shi & (fn == 5'h01 || fn == 5'h09 || fn == 5'h11);

        assign inst_slti  = op_hi == 10'h008;
        assign inst_sltui = op_hi == 10'h009;
        assign inst_addi  = op_hi == 10'h00a;
        assign inst_andi  = op_hi == 10'h00d;
        assign inst_ori   = op_hi == 10'h00e;
        assign inst_xori  = op_hi == 10'h00f;
        assign inst_ld_w  = op_hi == 10'h0a2;
        assign inst_st_w  = op_hi == 10'h0a6;
        assign inst_lu12i = inst[31:25] == 7'b0001010;
        assign inst_pcadd = inst[31:25] == 7'b0001110;
        assign is_jirl    = inst[31:26] == 6'h13;
        assign inst_b     = inst[31:26] == 6'h14;
        assign inst_bl    = inst[31:26] == 6'h15;
        assign is_beq     = inst[31:26] == 6'h16;
        assign is_bne     = inst[31:26] == 6'h17;
        assign is_blt     = inst[31:26] == 6'h18;
        assign is_bge     = inst[31:26] == 6'h19;
        assign is_bltu    = inst[31:26] == 6'h1a;
        assign is_bgeu    = inst[31:26] == 6'h1b;
        assign is_uncond  = inst_b | inst_bl;

        assign alu_op[id_pkg::ALU_ADD]  = is_3r & (fn == 5'h00) | inst_addi | inst_ld_w
                                        | inst_st_w | is_jirl | inst_bl | inst_pcadd;
        assign alu_op[id_pkg::ALU_SUB]  = is_3r & (fn == 5'h02);
        assign alu_op[id_pkg::ALU_SLT]  = is_3r & (fn == 5'h04) | inst_slti;
        assign alu_op[id_pkg::ALU_SLTU] = is_3r & (fn == 5'h05) | inst_sltui;
        assign alu_op[id_pkg::ALU_AND]  = is_3r & (fn == 5'h09) | inst_andi;
        assign alu_op[id_pkg::ALU_NOR]  = is_3r & (fn == 5'h08);
        assign alu_op[id_pkg::ALU_OR]   = is_3r & (fn == 5'h0a) | inst_ori;
        assign alu_op[id_pkg::ALU_XOR]  = is_3r & (fn == 5'h0b) | inst_xori;
        assign alu_op[id_pkg::ALU_SLL]  = is_3r & (fn == 5'h0e) | is_shi & (fn == 5'h01);
        assign alu_op[id_pkg::ALU_SRL]  = is_3r & (fn == 5'h0f) | is_shi & (fn == 5'h09);
        assign alu_op[id_pkg::ALU_SRA]  = is_3r & (fn == 5'h10) | is_shi & (fn == 5'h11);
        assign alu_op[id_pkg::ALU_LUI]  = inst_lu12i;

        // jirl carries its si16 offset here, EX sees 4 via the link mux
        assign imm = is_jirl                  ? {{14{inst[25]}}, inst[25:10], 2'b0} :
                     inst_lu12i | inst_pcadd  ? {inst[24:5], 12'b0} :
                     inst_andi | inst_ori | inst_xori ? {20'b0, inst[21:10]} :
                     {{20{inst[21]}}, inst[21:10]};

        assign br_offs = is_uncond ? {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0}
                                   : {{14{inst[25]}}, inst[25:10], 2'b0};

        assign src_reg_is_rd = is_beq | is_bne | is_blt | is_bge | is_bltu | is_bgeu | inst_st_w;
        assign raddr2        = src_reg_is_rd ? rd : inst[14:10];

        assign src1_is_pc   = is_jirl | inst_bl | inst_pcadd;
        assign src2_is_imm  = sh_imm | inst_addi | inst_slti | inst_sltui | inst_andi
                            | inst_ori | inst_xori | inst_ld_w | inst_st_w | inst_lu12i
                            | inst_pcadd | is_jirl | inst_bl;
        assign mem_we       = inst_st_w;
        assign res_from_mem = inst_ld_w;
        assign gr_we        = (|alu_op) & ~inst_st_w;   // unknown words write nothing
        assign dest         = inst_bl ? id_pkg::LINK_REG : rd;

        assert property (@(posedge clk) disable iff (rst) $onehot0(alu_op));

endmodule

/* rtl/id_pkg.sv */
package id_pkg;

        typedef logic [31:0] word_t;            // data or address word
        typedef logic [31:0] inst_t;
        typedef logic [4:0]  reg_addr_t;
        typedef logic [11:0] alu_op_t;          // one-hot, zero for no-op

        localparam int ALU_ADD  = 0;            // also address and link adds
        localparam int ALU_SUB  = 1;
        localparam int ALU_SLT  = 2;
        localparam int ALU_SLTU = 3;
        localparam int ALU_AND  = 4;
        localparam int ALU_NOR  = 5;
        localparam int ALU_OR   = 6;
        localparam int ALU_XOR  = 7;
        localparam int ALU_SLL  = 8;
        localparam int ALU_SRL  = 9;
        localparam int ALU_SRA  = 10;
        localparam int ALU_LUI  = 11;

        localparam reg_addr_t LINK_REG = 5'd1;  // bl return address

        typedef enum logic {
                ST_EMPTY,
                ST_HOLD
        } stage_state_t;

endpackage
